/* sources.f */
source/arb_pkg.sv
source/mem_pkg.sv
source/lzc.sv
source/rr_arb_tree.sv
source/rw_combiner.sv
source/mem_req_arbiter.sv
tb/tb_mem_req_arbiter.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= tb_mem_req_arbiter
RTL_TOP    ?= mem_req_arbiter
FILELIST   ?= sources.f
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_mem_req_arbiter.sv */
// testbench for the memory request arbiter
// a table of directed tests checked against a reference model of the pointer
// and preference rules, then random traffic with a fairness check
module tb_mem_req_arbiter;

  localparam int NumM          = arb_pkg::NumMasters;
  localparam int RstCycles     = 16;
  localparam int RandCycles    = 400;
  localparam int DrainCycles   = 40;
  localparam int CyclesPerXfer = 40;

  logic                                          clk;
  logic                                          rst_n;
  logic [NumM-1:0]                               rd_valid;
  logic [NumM-1:0]                               rd_ready;
  logic [NumM-1:0][mem_pkg::AddrWidth-1:0]       rd_addr;
  logic [NumM-1:0][mem_pkg::LenWidth-1:0]        rd_len;
  logic [NumM-1:0]                               wr_valid;
  logic [NumM-1:0]                               wr_ready;
  logic [NumM-1:0][mem_pkg::AddrWidth-1:0]       wr_addr;
  logic [NumM-1:0][mem_pkg::DataWidth-1:0]       wr_data;
  logic                                          mem_valid;
  logic                                          mem_ready;
  logic                                          mem_we;
  logic [arb_pkg::MasterIdxWidth-1:0]            mem_master;
  mem_pkg::mem_word_u                            mem_word;

  // request state per channel, index 0 is read and 1 is write
  // for reads only the low bits of req_aux carry the burst length
  logic [NumM-1:0] req_vld [2];
  logic [15:0]     req_addr [2][NumM];
  logic [15:0]     req_aux [2][NumM];

  // reference model state
  int rr_ptr [2];
  bit pref_wr;

  // random phase bookkeeping
  bit served [2][NumM];
  bit fresh [2][NumM];
  int waited [2][NumM];

  int errors;
  int fails;
  int limit_cycles;

  // directed test table
  string           t_name [$];
  logic [NumM-1:0] t_rd [$];
  logic [NumM-1:0] t_wr [$];
  logic [15:0]     t_rdy [$];
  string           t_order [$];

  always #10 clk = ~clk;

  always_comb begin
    rd_valid = req_vld[0];
    wr_valid = req_vld[1];
    for (int m = 0; m < NumM; m++) begin
      rd_addr[m] = req_addr[0][m];
      rd_len[m]  = req_aux[0][m][mem_pkg::LenWidth-1:0];
      wr_addr[m] = req_addr[1][m];
      wr_data[m] = req_aux[1][m];
    end
  end

  mem_req_arbiter i_mem_req_arbiter (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .rd_valid_i   ( rd_valid   ),
    .rd_ready_o   ( rd_ready   ),
    .rd_addr_i    ( rd_addr    ),
    .rd_len_i     ( rd_len     ),
    .wr_valid_i   ( wr_valid   ),
    .wr_ready_o   ( wr_ready   ),
    .wr_addr_i    ( wr_addr    ),
    .wr_data_i    ( wr_data    ),
    .mem_valid_o  ( mem_valid  ),
    .mem_ready_i  ( mem_ready  ),
    .mem_we_o     ( mem_we     ),
    .mem_master_o ( mem_master ),
    .mem_word_o   ( mem_word   )
  );

  //////////////////////////////////////////////////
  // reporting and the reference model
  //////////////////////////////////////////////////

  task automatic report_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    $display("[ERROR] %s: %s expected 0x%0h, got 0x%0h", name, what, exp, act);
    errors++;
  endtask

  task automatic report_problem(string name, string msg);
    $display("[ERROR] %s: %s", name, msg);
    errors++;
  endtask

  // first pending master at or after the pointer, in rotating order
  function automatic int pick_master(logic [NumM-1:0] pend, int ptr);
    int idx;
    for (int k = 0; k < NumM; k++) begin
      idx = (ptr + k) % NumM;
      if (pend[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  // next pending master above the served one, wrapping to the lowest
  function automatic int next_ptr(logic [NumM-1:0] pend, int served_idx);
    int idx;
    for (int k = 1; k <= NumM; k++) begin
      idx = (served_idx + k) % NumM;
      if (pend[idx]) begin
        return idx;
      end
    end
    return served_idx;
  endfunction

  task automatic add_entry(string name, logic [NumM-1:0] rd, logic [NumM-1:0] wr,
                           logic [15:0] rdy, string order);
    t_name.push_back(name);
    t_rd.push_back(rd);
    t_wr.push_back(wr);
    t_rdy.push_back(rdy);
    t_order.push_back(order);
  endtask

  // order strings list transfers as channel letter and master index
  // ready patterns give mem_ready_i per cycle from bit 0, high after bit 15
  task automatic load_table();
    add_entry("single_read",     4'b0100, 4'b0000, 16'hffff, "R2");
    add_entry("all_reads",       4'b1111, 4'b0000, 16'hffff, "R0R1R2R3");
    add_entry("all_writes",      4'b0000, 4'b1111, 16'hffff, "W0W1W2W3");
    add_entry("read_stall",      4'b1101, 4'b0000, 16'hffe0, "R0R2R3");
    add_entry("mixed_alternate", 4'b1111, 4'b1010, 16'hffff, "R0W1R1W3R2R3");
    add_entry("single_write",    4'b0000, 4'b0010, 16'hfff8, "W1");
  endtask

  task automatic apply_reset(string name);
    rst_n      = 1'b0;
    req_vld[0] = '0;
    req_vld[1] = '0;
    mem_ready  = 1'b0;
    repeat (RstCycles) @(posedge clk);
    #2;
    rst_n     = 1'b1;
    mem_ready = 1'b1;
    // with no master valid the port must stay idle even while ready is offered
    @(negedge clk);
    assert (!mem_valid && rd_ready == '0 && wr_ready == '0)
      else report_problem(name, "port not idle after reset with no requests");
  endtask

  // checks the port against the request state in one cycle
  task automatic check_cycle(string name, output bit xfer, output bit ch, output int m);
    logic             any_req;
    logic [31:0]      exp_word;
    logic [31:0]      act_word;
    logic [2*NumM-1:0] exp_rdy;
    any_req = (req_vld[0] != '0) || (req_vld[1] != '0);
    ch      = mem_we;
    m       = int'(mem_master);
    xfer    = mem_valid && mem_ready;
    exp_rdy = '0;
    assert (mem_valid == any_req)
      else report_value(name, "mem_valid_o", 32'(any_req), 32'(mem_valid));
    if (mem_valid) begin
      assert (req_vld[ch][m])
        else report_problem(name, $sformatf("request offered for idle master %0d", m));
      // decode the word through the view that mem_we_o selects
      if (ch) begin
        exp_word = {req_addr[1][m], req_aux[1][m]};
        act_word = {mem_word.wr.addr, mem_word.wr.data};
      end else begin
        exp_word = {req_addr[0][m], req_aux[0][m][mem_pkg::LenWidth-1:0], 8'h00};
        act_word = {mem_word.rd.addr, mem_word.rd.len, mem_word.rd.rsvd};
      end
      assert (act_word == exp_word) else report_value(name, "request word", exp_word, act_word);
      if (mem_ready) begin
        exp_rdy[int'(ch) * NumM + m] = 1'b1;
      end
    end
    assert ({wr_ready, rd_ready} == exp_rdy)
      else report_value(name, "ready vector {wr,rd}", 32'(exp_rdy), 32'({wr_ready, rd_ready}));
  endtask

  task automatic finish_test(string name, int errs_before);
    if (errors == errs_before) begin
      $display("test %-16s passed", name);
    end else begin
      $display("test %-16s failed with %0d errors", name, errors - errs_before);
      fails++;
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic run_entry(int t);
    string       name;
    string       order;
    int          n_xfer;
    int          done;
    int          cyc;
    int          m;
    int          exp_m;
    int          pred_m;
    int          errs_before;
    bit          ch;
    bit          exp_ch;
    bit          pred_ch;
    bit          xfer;
    bit          stalled;
    logic [31:0] hold_word;
    logic [2:0]  hold_sel;
    name        = t_name[t];
    order       = t_order[t];
    n_xfer      = order.len() / 2;
    errs_before = errors;
    done        = 0;
    cyc         = 0;
    stalled     = 1'b0;
    apply_reset(name);
    rr_ptr[0] = 0;
    rr_ptr[1] = 0;
    pref_wr   = 1'b0;
    @(posedge clk);
    #2;
    // payloads differ per master and per test
    for (int i = 0; i < NumM; i++) begin
      req_addr[0][i] = 16'(16'h1000 * (i + 1) + t * 16'h0101);
      req_aux[0][i]  = 16'(8'h20 + 4 * t + i);
      req_addr[1][i] = 16'(16'h8000 + 16'h0040 * i + t);
      req_aux[1][i]  = 16'(16'hd000 ^ (i << 8) ^ (t << 2));
    end
    req_vld[0] = t_rd[t];
    req_vld[1] = t_wr[t];
    mem_ready  = t_rdy[t][0];
    while (done < n_xfer && cyc < n_xfer * CyclesPerXfer) begin
      @(negedge clk);
      check_cycle(name, xfer, ch, m);
      pred_ch = (req_vld[0] != '0 && req_vld[1] != '0) ? pref_wr : (req_vld[1] != '0);
      pred_m  = pick_master(req_vld[pred_ch], rr_ptr[pred_ch]);
      if (mem_valid) begin
        assert (ch == pred_ch && m == pred_m)
          else report_value(name, "model channel and master",
                            32'((int'(pred_ch) << 4) | pred_m), 32'((int'(ch) << 4) | m));
        // a stalled port must hold its master, channel and word
        if (!mem_ready) begin
          if (stalled) begin
            assert (hold_word == mem_word) else report_value(name, "held word", hold_word, mem_word);
            assert (hold_sel == {mem_we, mem_master})
              else report_value(name, "held channel and master", 32'(hold_sel),
                                32'({mem_we, mem_master}));
          end
          hold_word = mem_word;
          hold_sel  = {mem_we, mem_master};
          stalled   = 1'b1;
        end else begin
          stalled = 1'b0;
        end
      end
      if (xfer) begin
        exp_ch = (order[2*done] == "W");
        exp_m  = int'(order[2*done+1]) - 48;
        assert (ch == exp_ch && m == exp_m)
          else report_value(name, $sformatf("transfer %0d channel and master", done),
                            32'((int'(exp_ch) << 4) | exp_m), 32'((int'(ch) << 4) | m));
        rr_ptr[ch] = next_ptr(req_vld[ch], m);
        pref_wr    = !ch;
        done++;
      end
      @(posedge clk);
      #2;
      if (xfer) begin
        req_vld[ch][m] = 1'b0;
      end
      cyc++;
      mem_ready = (cyc < 16) ? t_rdy[t][cyc] : 1'b1;
    end
    if (done < n_xfer) begin
      report_problem(name, $sformatf("only %0d of %0d transfers seen", done, n_xfer));
    end
    req_vld[0] = '0;
    req_vld[1] = '0;
    finish_test(name, errs_before);
  endtask

  //////////////////////////////////////////////////
  // random traffic
  //////////////////////////////////////////////////

  task automatic run_random();
    string name;
    int    errs_before;
    int    m;
    bit    ch;
    bit    xfer;
    name        = "random_traffic";
    errs_before = errors;
    for (int c = 0; c < 2; c++) begin
      for (int i = 0; i < NumM; i++) begin
        served[c][i] = 1'b0;
        fresh[c][i]  = 1'b0;
        waited[c][i] = 0;
      end
    end
    for (int cyc = 0; cyc < RandCycles; cyc++) begin
      @(posedge clk);
      #2;
      for (int c = 0; c < 2; c++) begin
        for (int i = 0; i < NumM; i++) begin
          if (served[c][i]) begin
            req_vld[c][i] = 1'b0;
            served[c][i]  = 1'b0;
          end
          // new requests stop before the end so the queues drain
          if (!req_vld[c][i] && cyc < RandCycles - DrainCycles && $urandom % 4 == 0) begin
            req_vld[c][i]  = 1'b1;
            req_addr[c][i] = 16'($urandom);
            req_aux[c][i]  = 16'($urandom);
            fresh[c][i]    = 1'b1;
            waited[c][i]   = 0;
          end
        end
      end
      mem_ready = (cyc >= RandCycles - DrainCycles) || ($urandom % 3 != 0);
      @(negedge clk);
      check_cycle(name, xfer, ch, m);
      if (xfer) begin
        assert (waited[ch][m] <= NumM)
          else report_problem(name, $sformatf("master %0d waited %0d transfers of its channel",
                                              m, waited[ch][m]));
        served[ch][m] = 1'b1;
        // a request raised this cycle does not count the transfer against itself
        for (int i = 0; i < NumM; i++) begin
          if (req_vld[ch][i] && i != m && !fresh[ch][i]) begin
            waited[ch][i]++;
          end
        end
      end
      for (int c = 0; c < 2; c++) begin
        for (int i = 0; i < NumM; i++) begin
          fresh[c][i] = 1'b0;
        end
      end
    end
    for (int c = 0; c < 2; c++) begin
      for (int i = 0; i < NumM; i++) begin
        if (req_vld[c][i] && !served[c][i]) begin
          report_problem(name, $sformatf("channel %0d master %0d never served", c, i));
        end
      end
    end
    @(posedge clk);
    #2;
    req_vld[0] = '0;
    req_vld[1] = '0;
    finish_test(name, errs_before);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int total;
    void'($urandom(10));
    clk          = 1'b0;
    rst_n        = 1'b0;
    mem_ready    = 1'b0;
    errors       = 0;
    fails        = 0;
    limit_cycles = 0;
    total        = 0;
    for (int c = 0; c < 2; c++) begin
      req_vld[c] = '0;
      for (int i = 0; i < NumM; i++) begin
        req_addr[c][i] = '0;
        req_aux[c][i]  = '0;
      end
    end
    load_table();
    foreach (t_order[t]) begin
      total += t_order[t].len() / 2;
    end
    // margin covers the resets and the random phase
    limit_cycles = total * CyclesPerXfer + t_name.size() * (RstCycles + 2) + RandCycles + 200;
    foreach (t_name[t]) begin
      run_entry(t);
    end
    run_random();
    $display("tests run: %0d, tests failed: %0d, errors: %0d", t_name.size() + 1, fails, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run hung", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* source/mem_req_arbiter.sv */
// memory request arbiter
// one round-robin tree per channel feeds a combiner that drives the
// single memory request port
module mem_req_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // read requests, one lane per master
  input  logic [arb_pkg::NumMasters-1:0]                        rd_valid_i,
  output logic [arb_pkg::NumMasters-1:0]                        rd_ready_o,
  input  logic [arb_pkg::NumMasters-1:0][mem_pkg::AddrWidth-1:0] rd_addr_i,
  input  logic [arb_pkg::NumMasters-1:0][mem_pkg::LenWidth-1:0]  rd_len_i,
  // write requests, one lane per master
  input  logic [arb_pkg::NumMasters-1:0]                        wr_valid_i,
  output logic [arb_pkg::NumMasters-1:0]                        wr_ready_o,
  input  logic [arb_pkg::NumMasters-1:0][mem_pkg::AddrWidth-1:0] wr_addr_i,
  input  logic [arb_pkg::NumMasters-1:0][mem_pkg::DataWidth-1:0] wr_data_i,
  // memory request port
  output logic                                                  mem_valid_o,
  input  logic                                                  mem_ready_i,
  output logic                                                  mem_we_o,
  output logic [arb_pkg::MasterIdxWidth-1:0]                    mem_master_o,
  output mem_pkg::mem_word_u                                    mem_word_o
);

  // tree lanes carry the address above the length or data
  logic [arb_pkg::NumMasters-1:0][mem_pkg::RdLaneWidth-1:0] rd_lanes;
  logic [arb_pkg::NumMasters-1:0][mem_pkg::WrLaneWidth-1:0] wr_lanes;

  // read winner
  logic                               rd_win_valid;
  logic                               rd_win_ready;
  logic [mem_pkg::RdLaneWidth-1:0]    rd_win_lane;
  logic [arb_pkg::MasterIdxWidth-1:0] rd_win_idx;
  logic [mem_pkg::AddrWidth-1:0]      rd_win_addr;
  logic [mem_pkg::LenWidth-1:0]       rd_win_len;

  // write winner
  logic                               wr_win_valid;
  logic                               wr_win_ready;
  logic [mem_pkg::WrLaneWidth-1:0]    wr_win_lane;
  logic [arb_pkg::MasterIdxWidth-1:0] wr_win_idx;
  logic [mem_pkg::AddrWidth-1:0]      wr_win_addr;
  logic [mem_pkg::DataWidth-1:0]      wr_win_data;

  for (genvar m = 0; m < arb_pkg::NumMasters; m++) begin : gen_lanes
    assign rd_lanes[m] = {rd_addr_i[m], rd_len_i[m]};
    assign wr_lanes[m] = {wr_addr_i[m], wr_data_i[m]};
  end

  assign {rd_win_addr, rd_win_len}  = rd_win_lane;
  assign {wr_win_addr, wr_win_data} = wr_win_lane;

  rr_arb_tree #(
    .NumIn     ( arb_pkg::NumMasters  ),
    .DataWidth ( mem_pkg::RdLaneWidth )
  ) i_rd_arb (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .valid_i ( rd_valid_i   ),
    .ready_o ( rd_ready_o   ),
    .data_i  ( rd_lanes     ),
    .valid_o ( rd_win_valid ),
    .ready_i ( rd_win_ready ),
    .data_o  ( rd_win_lane  ),
    .idx_o   ( rd_win_idx   )
  );

  rr_arb_tree #(
    .NumIn     ( arb_pkg::NumMasters  ),
    .DataWidth ( mem_pkg::WrLaneWidth )
  ) i_wr_arb (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .valid_i ( wr_valid_i   ),
    .ready_o ( wr_ready_o   ),
    .data_i  ( wr_lanes     ),
    .valid_o ( wr_win_valid ),
    .ready_i ( wr_win_ready ),
    .data_o  ( wr_win_lane  ),
    .idx_o   ( wr_win_idx   )
  );

  rw_combiner i_combiner (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rd_valid_i   ( rd_win_valid ),
    .rd_ready_o   ( rd_win_ready ),
    .rd_addr_i    ( rd_win_addr  ),
    .rd_len_i     ( rd_win_len   ),
    .rd_master_i  ( rd_win_idx   ),
    .wr_valid_i   ( wr_win_valid ),
    .wr_ready_o   ( wr_win_ready ),
    .wr_addr_i    ( wr_win_addr  ),
    .wr_data_i    ( wr_win_data  ),
    .wr_master_i  ( wr_win_idx   ),
    .mem_valid_o  ( mem_valid_o  ),
    .mem_ready_i  ( mem_ready_i  ),
    .mem_we_o     ( mem_we_o     ),
    .mem_master_o ( mem_master_o ),
    .mem_word_o   ( mem_word_o   )
  );

endmodule

/* source/rw_combiner.sv */
// read/write combiner
// alternates between the read winner and the write winner and builds the
// memory request word for the chosen channel
module rw_combiner (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // read winner
  input  logic                               rd_valid_i,
  output logic                               rd_ready_o,
  input  logic [mem_pkg::AddrWidth-1:0]      rd_addr_i,
  input  logic [mem_pkg::LenWidth-1:0]       rd_len_i,
  input  logic [arb_pkg::MasterIdxWidth-1:0] rd_master_i,
  // write winner
  input  logic                               wr_valid_i,
  output logic                               wr_ready_o,
  input  logic [mem_pkg::AddrWidth-1:0]      wr_addr_i,
  input  logic [mem_pkg::DataWidth-1:0]      wr_data_i,
  input  logic [arb_pkg::MasterIdxWidth-1:0] wr_master_i,
  // memory request port
  output logic                               mem_valid_o,
  input  logic                               mem_ready_i,
  output logic                               mem_we_o,
  output logic [arb_pkg::MasterIdxWidth-1:0] mem_master_o,
  output mem_pkg::mem_word_u                 mem_word_o
);

  logic pref_q;
  logic lock_q;
  logic lock_chan_q;
  logic sel_chan;

  // a stall keeps the channel chosen last cycle
  // otherwise a lone valid channel passes and the preference settles a tie
  always_comb begin
    if (lock_q) begin
      sel_chan = lock_chan_q;
    end else if (rd_valid_i && wr_valid_i) begin
      sel_chan = pref_q;
    end else if (wr_valid_i) begin
      sel_chan = arb_pkg::ChanWr;
    end else begin
      sel_chan = arb_pkg::ChanRd;
    end
  end

  assign mem_valid_o  = rd_valid_i | wr_valid_i;
  assign mem_we_o     = (sel_chan == arb_pkg::ChanWr);
  assign mem_master_o = mem_we_o ? wr_master_i : rd_master_i;

  // only the chosen side sees the memory ready
  assign rd_ready_o = mem_ready_i & ~mem_we_o;
  assign wr_ready_o = mem_ready_i & mem_we_o;

  // fill the view that matches the channel, reserved read bits stay zero
  always_comb begin
    mem_word_o = '0;
    if (mem_we_o) begin
      mem_word_o.wr.addr = wr_addr_i;
      mem_word_o.wr.data = wr_data_i;
    end else begin
      mem_word_o.rd.addr = rd_addr_i;
      mem_word_o.rd.len  = rd_len_i;
    end
  end

  // after every transfer the other channel gets the preference
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pref_q      <= arb_pkg::ChanRd;
      lock_q      <= 1'b0;
      lock_chan_q <= arb_pkg::ChanRd;
    end else begin
      if (mem_valid_o && mem_ready_i) begin
        pref_q <= mem_we_o ? arb_pkg::ChanRd : arb_pkg::ChanWr;
      end
      lock_q      <= mem_valid_o & ~mem_ready_i;
      lock_chan_q <= sel_chan;
    end
  end

endmodule

/* source/rr_arb_tree.sv */
// logarithmic round-robin arbitration tree
// picks one valid input per cycle with a fair priority pointer and keeps
// its choice while the output is held off by back-pressure
module rr_arb_tree #(
  parameter int unsigned NumIn     = arb_pkg::NumMasters,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [NumIn-1:0]                    valid_i,
  output logic [NumIn-1:0]                    ready_o,
  input  logic [NumIn-1:0][DataWidth-1:0]     data_i,
  output logic                                valid_o,
  input  logic                                ready_i,
  output logic [DataWidth-1:0]                data_o,
  output logic [arb_pkg::MasterIdxWidth-1:0]  idx_o
);

  // request vector seen by the tree, frozen while locked
  logic [NumIn-1:0] req_d;
  logic [NumIn-1:0] req_q;
  logic             lock_q;

  // priority pointer and its fair update
  logic [arb_pkg::MasterIdxWidth-1:0] rr_q;
  logic [arb_pkg::MasterIdxWidth-1:0] rr_d;
  logic [arb_pkg::MasterIdxWidth-1:0] next_idx;
  logic [arb_pkg::MasterIdxWidth-1:0] upper_idx;
  logic [arb_pkg::MasterIdxWidth-1:0] lower_idx;
  logic                               upper_empty;
  logic                               lower_empty;
  logic [NumIn-1:0]                   upper_mask;
  logic [NumIn-1:0]                   lower_mask;

  // leaves padded to a full tree, unused leaves never request
  logic [2**arb_pkg::MasterIdxWidth-1:0]                req_pad;
  logic [2**arb_pkg::MasterIdxWidth-1:0]                gnt_pad;
  logic [2**arb_pkg::MasterIdxWidth-1:0][DataWidth-1:0] data_pad;

  // tree nodes, node 0 is the root
  logic [2**arb_pkg::MasterIdxWidth-2:0] req_nodes;
  logic [2**arb_pkg::MasterIdxWidth-2:0] gnt_nodes;
  logic [2**arb_pkg::MasterIdxWidth-2:0][arb_pkg::MasterIdxWidth-1:0] idx_nodes;
  logic [2**arb_pkg::MasterIdxWidth-2:0][DataWidth-1:0] data_nodes;

  //////////////////////////////////////////////////
  // lock and request registers
  //////////////////////////////////////////////////

  // a stalled output replays last cycle's request vector
  // masters keep valid high until served, so this set is still live
  assign req_d = lock_q ? req_q : valid_i;

  always_comb begin
    req_pad  = '0;
    data_pad = '0;
    req_pad[NumIn-1:0]  = req_d;
    data_pad[NumIn-1:0] = data_i;
  end

  //////////////////////////////////////////////////
  // fair next priority
  //////////////////////////////////////////////////

  // split the requests around the input being served
  for (genvar i = 0; i < NumIn; i++) begin : gen_mask
    assign upper_mask[i] = (i > idx_o) ? req_d[i] : 1'b0;
    assign lower_mask[i] = (i <= idx_o) ? req_d[i] : 1'b0;
  end

  lzc #(
    .WIDTH ( NumIn )
  ) i_lzc_upper (
    .in_i    ( upper_mask  ),
    .cnt_o   ( upper_idx   ),
    .empty_o ( upper_empty )
  );

  lzc #(
    .WIDTH ( NumIn )
  ) i_lzc_lower (
    .in_i    ( lower_mask  ),
    .cnt_o   ( lower_idx   ),
    .empty_o ( lower_empty )
  );

  // next request above the served one, else wrap to the lowest one
  assign next_idx = !upper_empty ? upper_idx : (!lower_empty ? lower_idx : rr_q);
  assign rr_d     = (valid_o && ready_i) ? next_idx : rr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= valid_o & ~ready_i;
      req_q  <= req_d;
    end
  end

  //////////////////////////////////////////////////
  // arbitration tree
  //////////////////////////////////////////////////

  assign gnt_nodes[0] = ready_i;

  for (genvar lvl = 0; lvl < arb_pkg::MasterIdxWidth; lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      logic                               sel;
      logic                               lo_req;
      logic                               hi_req;
      logic [arb_pkg::MasterIdxWidth-1:0] lo_idx;
      logic [arb_pkg::MasterIdxWidth-1:0] hi_idx;
      logic [arb_pkg::MasterIdxWidth-1:0] node_idx;
      logic [DataWidth-1:0]               lo_data;
      logic [DataWidth-1:0]               hi_data;

      if (lvl == arb_pkg::MasterIdxWidth - 1) begin : gen_leaf
        assign lo_req  = req_pad[2*n];
        assign hi_req  = req_pad[2*n+1];
        assign lo_idx  = '0;
        assign hi_idx  = '0;
        assign lo_data = data_pad[2*n];
        assign hi_data = data_pad[2*n+1];
        // only a requesting leaf can see a grant
        assign gnt_pad[2*n]   = gnt_nodes[2**lvl-1+n] & ~sel & lo_req;
        assign gnt_pad[2*n+1] = gnt_nodes[2**lvl-1+n] & sel & hi_req;
      end else begin : gen_inner
        assign lo_req  = req_nodes[2**(lvl+1)-1+2*n];
        assign hi_req  = req_nodes[2**(lvl+1)+2*n];
        assign lo_idx  = idx_nodes[2**(lvl+1)-1+2*n];
        assign hi_idx  = idx_nodes[2**(lvl+1)+2*n];
        assign lo_data = data_nodes[2**(lvl+1)-1+2*n];
        assign hi_data = data_nodes[2**(lvl+1)+2*n];
        assign gnt_nodes[2**(lvl+1)-1+2*n] = gnt_nodes[2**lvl-1+n] & ~sel;
        assign gnt_nodes[2**(lvl+1)+2*n]   = gnt_nodes[2**lvl-1+n] & sel;
      end

      // the pointer bit of this level breaks a tie between both halves
      assign sel = ~lo_req | (hi_req & rr_q[arb_pkg::MasterIdxWidth-1-lvl]);

      // each level contributes one bit of the winning index
      always_comb begin
        node_idx = sel ? hi_idx : lo_idx;
        node_idx[arb_pkg::MasterIdxWidth-1-lvl] = sel;
      end

      assign req_nodes[2**lvl-1+n]  = lo_req | hi_req;
      assign idx_nodes[2**lvl-1+n]  = node_idx;
      assign data_nodes[2**lvl-1+n] = sel ? hi_data : lo_data;
    end
  end

  // root of the tree is the arbiter output
  assign valid_o = req_nodes[0];
  assign data_o  = data_nodes[0];
  assign idx_o   = idx_nodes[0];
  assign ready_o = gnt_pad[NumIn-1:0];

endmodule

/* source/lzc.sv */
// trailing-zero counter
// returns the index of the lowest set bit and flags an all-zero input
module lzc #(
  // needs at least two bits
  parameter int unsigned WIDTH = 4
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  // input padded up to a power of two, the extra bits stay zero
  logic [2**$clog2(WIDTH)-1:0] in_pad;
  // reduction nodes, node 0 is the root
  logic [2**$clog2(WIDTH)-2:0] vld_nodes;
  logic [2**$clog2(WIDTH)-2:0][$clog2(WIDTH)-1:0] idx_nodes;

  always_comb begin
    in_pad = '0;
    in_pad[WIDTH-1:0] = in_i;
  end

  for (genvar lvl = 0; lvl < $clog2(WIDTH); lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      logic lo_vld;
      logic hi_vld;
      logic [$clog2(WIDTH)-1:0] lo_idx;
      logic [$clog2(WIDTH)-1:0] hi_idx;
      logic [$clog2(WIDTH)-1:0] node_idx;

      if (lvl == $clog2(WIDTH) - 1) begin : gen_leaf
        // leaves look at two neighbouring input bits
        assign lo_vld = in_pad[2*n];
        assign hi_vld = in_pad[2*n+1];
        assign lo_idx = '0;
        assign hi_idx = '0;
      end else begin : gen_inner
        assign lo_vld = vld_nodes[2**(lvl+1)-1+2*n];
        assign hi_vld = vld_nodes[2**(lvl+1)+2*n];
        assign lo_idx = idx_nodes[2**(lvl+1)-1+2*n];
        assign hi_idx = idx_nodes[2**(lvl+1)+2*n];
      end

      // the lower half wins whenever it holds a set bit
      always_comb begin
        node_idx = lo_vld ? lo_idx : hi_idx;
        node_idx[$clog2(WIDTH)-1-lvl] = ~lo_vld;
      end

      assign vld_nodes[2**lvl-1+n] = lo_vld | hi_vld;
      assign idx_nodes[2**lvl-1+n] = node_idx;
    end
  end

  assign cnt_o   = idx_nodes[0];
  assign empty_o = ~vld_nodes[0];

endmodule

/* source/mem_pkg.sv */
// memory request port definitions
// field widths, tree lane widths and the request word with its read and write views
package mem_pkg;

  // address, read burst length and write data widths
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned DataWidth = 16;

  // the request word carries either view in the same 32 bits
  localparam int unsigned WordWidth = 32;
  // bits left over in the read view, always driven to zero
  localparam int unsigned RsvdWidth = WordWidth - AddrWidth - LenWidth;

  // payload lanes of the two trees, address in the upper bits
  localparam int unsigned RdLaneWidth = AddrWidth + LenWidth;
  localparam int unsigned WrLaneWidth = AddrWidth + DataWidth;

  // one request word, decoded by mem_we_o
  // low selects the rd view and high selects the wr view
  typedef union packed {
    struct packed {
      logic [AddrWidth-1:0] addr;
      logic [LenWidth-1:0]  len;
      logic [RsvdWidth-1:0] rsvd;
    } rd;
    struct packed {
      logic [AddrWidth-1:0] addr;
      logic [DataWidth-1:0] data;
    } wr;
  } mem_word_u;

endpackage

/* source/arb_pkg.sv */
// arbitration constants
// shared by the round-robin trees, the read/write combiner and the top level
package arb_pkg;

  //////////////////////////////////////////////////
  // master population
  //////////////////////////////////////////////////

  // number of masters that compete for the memory port
  localparam int unsigned NumMasters = 4;
  // width of a master index, also the depth of each arbitration tree
  localparam int unsigned MasterIdxWidth = $clog2(NumMasters);

  //////////////////////////////////////////////////
  // channel encoding used by the combiner
  //////////////////////////////////////////////////

  // the read channel is the preferred one right after reset
  localparam logic ChanRd = 1'b0;
  localparam logic ChanWr = 1'b1;

endpackage
